//--- src/spm_pkg.sv
`default_nettype none

package spm_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and defaults
    //////////////////////////////////////////////////////////////////////

    // Audio sample width, overridden from the top level
    parameter int SAMPLE_WIDTH_DEFAULT = 16;
    // Result FIFO depth in entries, power of two and at least 2
    parameter int FIFO_DEPTH_DEFAULT = 16;
    // Interval input and per-interval sample counter
    parameter int INTERVAL_WIDTH = 32;
    // Processing timer in clock cycles
    parameter int TIMER_WIDTH = 32;
    // Widest sample the constant helpers below can describe
    parameter int SAMPLE_MAX_WIDTH = 32;

    //////////////////////////////////////////////////////////////////////
    // Sample constants as functions of the sample width
    //////////////////////////////////////////////////////////////////////

    // End of stream marker has only the sign bit set
    function automatic logic [SAMPLE_MAX_WIDTH-1:0] end_marker(int unsigned width);
        return {{(SAMPLE_MAX_WIDTH - 1){1'b0}}, 1'b1} << (width - 1);
    endfunction

    // Most negative sample that is still data
    function automatic logic [SAMPLE_MAX_WIDTH-1:0] most_negative(int unsigned width);
        return end_marker(width) + 1'b1;
    endfunction

    // All ones below the sign bit
    function automatic logic [SAMPLE_MAX_WIDTH-1:0] most_positive(int unsigned width);
        return end_marker(width) - 1'b1;
    endfunction

endpackage

`default_nettype wire

//--- src/spm_control.sv
`default_nettype none
`timescale 1ns/10ps

module spm_control (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            enable,
    input  logic                            start,
    // Marker accepted by the tracker this cycle
    input  logic                            stream_end,
    output logic                            collecting,
    output logic [spm_pkg::TIMER_WIDTH-1:0] timer,
    output logic                            busy,
    output logic                            done
);

    import spm_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Run state
    //////////////////////////////////////////////////////////////////////

    // Two states only, idle and collecting samples
    localparam logic STATE_IDLE    = 1'b0;
    localparam logic STATE_COLLECT = 1'b1;

    logic state;
    // Start request seen while idle
    logic start_run;

    assign start_run = (state == STATE_IDLE) && start;

    // Tracker accepts samples only in the collect state
    assign collecting = (state == STATE_COLLECT);

    // Everything holds while enable is low
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= STATE_IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else if (enable) begin
            case (state)
                STATE_IDLE: begin
                    // New run clears done of the previous one
                    if (start_run) begin
                        state <= STATE_COLLECT;
                        busy  <= 1'b1;
                        done  <= 1'b0;
                    end
                end
                STATE_COLLECT: begin
                    // Marker ends the run, done stays until next start
                    if (stream_end) begin
                        state <= STATE_IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= STATE_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Processing timer
    //////////////////////////////////////////////////////////////////////

    // Counts every enabled cycle with busy high, marker cycle included
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer <= '0;
        end else if (enable) begin
            if (start_run) begin
                timer <= '0;
            end else if (busy) begin
                timer <= timer + TIMER_WIDTH'(1);
            end
        end
    end

    // Tracker must not see a marker unless a run is open
    a_end_only_in_run: assert property (
        @(posedge clk) disable iff (reset)
        stream_end |-> (state == STATE_COLLECT) && busy
    );

endmodule

`default_nettype wire

//--- src/interval_extrema.sv
`default_nettype none
`timescale 1ns/10ps

module interval_extrema #(
    parameter int SAMPLE_WIDTH = spm_pkg::SAMPLE_WIDTH_DEFAULT
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               enable,
    input  logic                               collecting,
    input  logic [spm_pkg::INTERVAL_WIDTH-1:0] interval,
    input  logic signed [SAMPLE_WIDTH-1:0]     data_in,
    input  logic                               data_in_valid,
    output logic                               data_in_ready,
    // Back-pressure from the two result FIFOs
    input  logic                               min_full,
    input  logic                               max_full,
    output logic                               push,
    output logic signed [SAMPLE_WIDTH-1:0]     push_min,
    output logic signed [SAMPLE_WIDTH-1:0]     push_max,
    output logic                               stream_end
);

    import spm_pkg::*;

    // Constants cut down to the sample width
    localparam logic [SAMPLE_MAX_WIDTH-1:0] MARKER_WIDE = end_marker(SAMPLE_WIDTH);
    localparam logic [SAMPLE_MAX_WIDTH-1:0] NEG_WIDE = most_negative(SAMPLE_WIDTH);
    localparam logic [SAMPLE_MAX_WIDTH-1:0] POS_WIDE = most_positive(SAMPLE_WIDTH);
    localparam logic signed [SAMPLE_WIDTH-1:0] END_MARKER = MARKER_WIDE[SAMPLE_WIDTH-1:0];
    localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_NEG = NEG_WIDE[SAMPLE_WIDTH-1:0];
    localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_POS = POS_WIDE[SAMPLE_WIDTH-1:0];

    logic [INTERVAL_WIDTH-1:0]     interval_q;
    logic [INTERVAL_WIDTH-1:0]     count;
    logic [INTERVAL_WIDTH-1:0]     count_next;
    logic signed [SAMPLE_WIDTH-1:0] run_min;
    logic signed [SAMPLE_WIDTH-1:0] run_max;
    logic signed [SAMPLE_WIDTH-1:0] cand_min;
    logic signed [SAMPLE_WIDTH-1:0] cand_max;
    logic accept;
    logic is_marker;
    logic last_sample;

    //////////////////////////////////////////////////////////////////////
    // Handshake and decode
    //////////////////////////////////////////////////////////////////////

    // Room in both FIFOs guarantees any push lands
    assign data_in_ready = enable && collecting && !min_full && !max_full;
    assign accept        = data_in_valid && data_in_ready;
    assign is_marker     = (data_in == END_MARKER);
    assign stream_end    = accept && is_marker;

    // Running extrema with the current sample folded in
    assign cand_min   = (data_in < run_min) ? data_in : run_min;
    assign cand_max   = (data_in > run_max) ? data_in : run_max;
    assign count_next = count + INTERVAL_WIDTH'(1);
    // This sample completes the interval
    assign last_sample = (count_next == interval_q);

    // Full interval, or a partial one flushed by the marker
    assign push = accept && (is_marker ? (count != '0) : last_sample);
    // Marker itself is never part of the result
    assign push_min = is_marker ? run_min : cand_min;
    assign push_max = is_marker ? run_max : cand_max;

    //////////////////////////////////////////////////////////////////////
    // Running state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interval_q <= '0;
            count      <= '0;
            run_min    <= SAMPLE_POS;
            run_max    <= SAMPLE_NEG;
        end else if (enable) begin
            if (!collecting) begin
                // Follow the input while idle, so the start edge latches it
                interval_q <= interval;
                count      <= '0;
                run_min    <= SAMPLE_POS;
                run_max    <= SAMPLE_NEG;
            end else if (accept) begin
                if (is_marker || last_sample) begin
                    // Interval reported, start a fresh one
                    count   <= '0;
                    run_min <= SAMPLE_POS;
                    run_max <= SAMPLE_NEG;
                end else begin
                    count   <= count_next;
                    run_min <= cand_min;
                    run_max <= cand_max;
                end
            end
        end
    end

    // A zero interval would never close, so start must bring a real one
    a_interval_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        $rose(collecting) |-> (interval_q != '0)
    );

endmodule

`default_nettype wire

//--- src/extrema_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module extrema_fifo #(
    parameter int SAMPLE_WIDTH = spm_pkg::SAMPLE_WIDTH_DEFAULT,
    parameter int FIFO_DEPTH   = spm_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wr_en,
    input  logic signed [SAMPLE_WIDTH-1:0] wr_data,
    output logic                           full,
    // Head of the queue, shown as soon as it is written
    output logic signed [SAMPLE_WIDTH-1:0] rd_data,
    output logic                           rd_valid,
    input  logic                           rd_ready
);

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // Pointers wrap naturally with a power of two depth
    generate
        if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_bad_depth
            $error("extrema_fifo depth must be a power of two and at least 2");
        end
    endgenerate

    logic signed [SAMPLE_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    // One extra bit to tell full from empty
    logic [ADDR_WIDTH:0]   count;
    logic                  rd_en;

    assign full     = (count == (ADDR_WIDTH + 1)'(FIFO_DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign rd_en    = rd_valid && rd_ready;

    //////////////////////////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + ADDR_WIDTH'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + ADDR_WIDTH'(1);
            end
            // Occupancy, unchanged on simultaneous push and pop
            case ({wr_en, rd_en})
                2'b10:   count <= count + (ADDR_WIDTH + 1)'(1);
                2'b01:   count <= count - (ADDR_WIDTH + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    // Writer holds off through data_in_ready, so full is never hit
    a_no_write_full: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> !full
    );

    // Stalled receiver sees the same head entry
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (reset)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_data)
    );

endmodule

`default_nettype wire

//--- src/spm_top.sv
`default_nettype none
`timescale 1ns/10ps

module spm_top #(
    parameter int SAMPLE_WIDTH = spm_pkg::SAMPLE_WIDTH_DEFAULT,
    parameter int FIFO_DEPTH   = spm_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               enable,
    input  logic                               start,
    input  logic [spm_pkg::INTERVAL_WIDTH-1:0] interval,
    // Sample stream in
    input  logic signed [SAMPLE_WIDTH-1:0]     data_in,
    input  logic                               data_in_valid,
    output logic                               data_in_ready,
    // Result streams out
    output logic signed [SAMPLE_WIDTH-1:0]     min_out,
    output logic signed [SAMPLE_WIDTH-1:0]     max_out,
    output logic                               min_out_valid,
    output logic                               max_out_valid,
    input  logic                               min_out_ready,
    input  logic                               max_out_ready,
    // Status
    output logic [spm_pkg::TIMER_WIDTH-1:0]    timer,
    output logic                               busy,
    output logic                               done
);

    logic                           collecting;
    logic                           stream_end;
    logic                           push;
    logic signed [SAMPLE_WIDTH-1:0] push_min;
    logic signed [SAMPLE_WIDTH-1:0] push_max;
    logic                           min_full;
    logic                           max_full;

    //////////////////////////////////////////////////////////////////////
    // Control and extrema tracking
    //////////////////////////////////////////////////////////////////////

    spm_control i_spm_control (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .start      (start),
        .stream_end (stream_end),
        .collecting (collecting),
        .timer      (timer),
        .busy       (busy),
        .done       (done)
    );

    interval_extrema #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) i_interval_extrema (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .collecting    (collecting),
        .interval      (interval),
        .data_in       (data_in),
        .data_in_valid (data_in_valid),
        .data_in_ready (data_in_ready),
        .min_full      (min_full),
        .max_full      (max_full),
        .push          (push),
        .push_min      (push_min),
        .push_max      (push_max),
        .stream_end    (stream_end)
    );

    //////////////////////////////////////////////////////////////////////
    // Result FIFOs, written together and read independently
    //////////////////////////////////////////////////////////////////////

    extrema_fifo #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) min_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (push),
        .wr_data  (push_min),
        .full     (min_full),
        .rd_data  (min_out),
        .rd_valid (min_out_valid),
        .rd_ready (min_out_ready)
    );

    extrema_fifo #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) max_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (push),
        .wr_data  (push_max),
        .full     (max_full),
        .rd_data  (max_out),
        .rd_valid (max_out_valid),
        .rd_ready (max_out_ready)
    );

endmodule

`default_nettype wire

//--- verification/spm_tests.svh
//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Min and max over the open interval become the next expected pair
task automatic close_interval();
    logic signed [15:0] lo;
    logic signed [15:0] hi;
    lo = pending[0];
    hi = pending[0];
    foreach (pending[i]) begin
        if (pending[i] < lo) begin
            lo = pending[i];
        end
        if (pending[i] > hi) begin
            hi = pending[i];
        end
    end
    exp_min.push_back(lo);
    exp_max.push_back(hi);
    pending.delete();
endtask

// Marker flushes a partial interval, an empty one gives nothing
task automatic model_accept(input logic signed [15:0] value);
    if (value == MARKER) begin
        if (pending.size() > 0) begin
            close_interval();
        end
    end else begin
        pending.push_back(value);
        if (pending.size() == cur_interval) begin
            close_interval();
        end
    end
endtask

task automatic feed(input logic signed [15:0] value);
    send_sample(value);
    model_accept(value);
endtask

task automatic feed_random(input int count);
    logic signed [15:0] value;
    repeat (count) begin
        random_sample(value);
        feed(value);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Run control and result readers
//////////////////////////////////////////////////////////////////////

task automatic start_run(input int length);
    interval     = INTERVAL_WIDTH'(length);
    cur_interval = length;
    busy_cycles  = 0;
    pending.delete();
    start = 1'b1;
    tick();
    start = 1'b0;
    expect_value("busy", busy, 1);
    expect_value("done", done, 0);
    expect_value("timer", timer, 0);
endtask

// Status flips on the cycle right after the marker is taken
task automatic end_stream();
    expect_value("busy", busy, 1);
    send_sample(MARKER);
    model_accept(MARKER);
    expect_value("busy", busy, 0);
    expect_value("done", done, 1);
endtask

task automatic pop_min();
    logic signed [15:0] want;
    min_out_ready = 1'b1;
    #1;
    while (!min_out_valid) begin
        @(posedge clk);
        #2;
    end
    want = exp_min.pop_front();
    expect_value("min_out", min_out, want);
    tick();
    min_out_ready = 1'b0;
endtask

task automatic pop_max();
    logic signed [15:0] want;
    max_out_ready = 1'b1;
    #1;
    while (!max_out_valid) begin
        @(posedge clk);
        #2;
    end
    want = exp_max.pop_front();
    expect_value("max_out", max_out, want);
    tick();
    max_out_ready = 1'b0;
endtask

// Reads every expected pair, then nothing may be left
task automatic drain_results();
    while (exp_min.size() > 0) begin
        pop_min();
    end
    while (exp_max.size() > 0) begin
        pop_max();
    end
    expect_value("min_out_valid", min_out_valid, 0);
    expect_value("max_out_valid", max_out_valid, 0);
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic check_reset_state();
    expect_value("busy", busy, 0);
    expect_value("done", done, 0);
    expect_value("data_in_ready", data_in_ready, 0);
    expect_value("min_out_valid", min_out_valid, 0);
    expect_value("max_out_valid", max_out_valid, 0);
    expect_value("timer", timer, 0);
endtask

// Three full intervals, extremes of the sample range among them
task automatic run_whole_intervals();
    start_run(4);
    feed(16'sd100);
    feed(-16'sd5);
    feed(SAMPLE_NEG);
    feed(16'sd20);
    feed(SAMPLE_POS);
    feed(16'sd3);
    feed(-16'sd200);
    feed(16'sd0);
    feed(-16'sd1);
    feed(16'sd1);
    feed(16'sd300);
    feed(-16'sd300);
    end_stream();
    drain_results();
endtask

// Ten samples leave two pending, eight leave none
task automatic run_final_intervals();
    start_run(4);
    feed_random(10);
    end_stream();
    drain_results();
    start_run(4);
    feed_random(8);
    end_stream();
    drain_results();
endtask

// Four pairs fill both FIFOs, min side is released before max side
task automatic stall_on_full_fifos();
    logic signed [15:0] held_sample;
    start_run(2);
    feed_random(8);
    expect_value("data_in_ready", data_in_ready, 0);
    expect_value("min_out_valid", min_out_valid, 1);
    expect_value("max_out_valid", max_out_valid, 1);
    random_sample(held_sample);
    fork
        begin
            feed(held_sample);
        end
        begin
            // Stalled receivers keep seeing the oldest pair
            repeat (3) begin
                tick();
                expect_value("data_in_ready", data_in_ready, 0);
                expect_value("min_out", min_out, exp_min[0]);
                expect_value("max_out", max_out, exp_max[0]);
            end
            repeat (FIFO_DEPTH) begin
                pop_min();
            end
            // Max FIFO still full
            tick();
            expect_value("data_in_ready", data_in_ready, 0);
            repeat (FIFO_DEPTH) begin
                pop_max();
            end
        end
    join
    feed_random(1);
    end_stream();
    drain_results();
endtask

task automatic timer_and_enable();
    int held_timer;
    start_run(3);
    feed_random(7);
    end_stream();
    expect_value("timer", timer, busy_cycles);
    drain_results();
    // Second run freezes for six cycles mid stream
    start_run(3);
    feed_random(4);
    enable     = 1'b0;
    // Enabled busy cycles so far, the value the timer must hold
    held_timer = busy_cycles;
    repeat (6) begin
        tick();
        expect_value("timer", timer, held_timer);
        expect_value("data_in_ready", data_in_ready, 0);
        expect_value("busy", busy, 1);
    end
    enable = 1'b1;
    feed_random(3);
    end_stream();
    expect_value("timer", timer, busy_cycles);
    drain_results();
endtask

//--- verification/spm_tb.sv
`default_nettype none
`timescale 1ns/10ps

module spm_tb;

    import spm_pkg::*;

    // Reserved and extreme values of a 16 bit sample stream
    localparam logic signed [15:0] MARKER     = 16'sh8000;
    localparam logic signed [15:0] SAMPLE_NEG = 16'sh8001;
    localparam logic signed [15:0] SAMPLE_POS = 16'sh7fff;
    // Shallow FIFOs so a full FIFO is reached after a few pairs
    localparam int FIFO_DEPTH   = 4;
    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 10;
    // Samples over all tests, markers included
    localparam int TEST_SAMPLES    = 60;
    // Cycles allowed per sample, covering stalls and result reads
    localparam int CYCLE_MARGIN    = 10;
    localparam int WATCHDOG_CYCLES = TEST_SAMPLES * CYCLE_MARGIN + 100;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      enable;
    logic                      start;
    logic [INTERVAL_WIDTH-1:0] interval;
    logic signed [15:0]        data_in;
    logic                      data_in_valid;
    logic                      data_in_ready;
    logic signed [15:0]        min_out;
    logic signed [15:0]        max_out;
    logic                      min_out_valid;
    logic                      max_out_valid;
    logic                      min_out_ready;
    logic                      max_out_ready;
    logic [TIMER_WIDTH-1:0]    timer;
    logic                      busy;
    logic                      done;

    int errors;
    int checks;
    // Enabled busy cycles of the current run
    int busy_cycles;
    // Interval length of the current run, for the model
    int cur_interval;
    logic [15:0] lfsr;

    // Model state: samples of the open interval, expected results in order
    logic signed [15:0] pending [$];
    logic signed [15:0] exp_min [$];
    logic signed [15:0] exp_max [$];

    spm_top #(
        .SAMPLE_WIDTH (16),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_spm_top (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .start         (start),
        .interval      (interval),
        .data_in       (data_in),
        .data_in_valid (data_in_valid),
        .data_in_ready (data_in_ready),
        .min_out       (min_out),
        .max_out       (max_out),
        .min_out_valid (min_out_valid),
        .max_out_valid (max_out_valid),
        .min_out_ready (min_out_ready),
        .max_out_ready (max_out_ready),
        .timer         (timer),
        .busy          (busy),
        .done          (done)
    );

    always #(CLK_HALF) clk = ~clk;

    // Mid cycle sample, each such cycle is one timer step at the next edge
    always @(negedge clk) begin
        if (busy && enable) begin
            busy_cycles++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Step to 1 ns after the next rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1, shifting right
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit, marker values are drawn again
    task automatic random_sample(output logic signed [15:0] value);
        do begin
            for (int b = 0; b < 16; b++) begin
                lfsr  = lfsr_next(lfsr);
                value = {value[14:0], lfsr[0]};
            end
        end while (value == MARKER);
    endtask

    // Holds data and valid until the DUT takes the sample
    task automatic send_sample(input logic signed [15:0] value);
        data_in       = value;
        data_in_valid = 1'b1;
        #1;
        while (!data_in_ready) begin
            @(posedge clk);
            #2;
        end
        tick();
        data_in_valid = 1'b0;
    endtask

    `include "spm_tests.svh"

    initial begin
        reset         = 1'b1;
        enable        = 1'b1;
        start         = 1'b0;
        interval      = '0;
        data_in       = '0;
        data_in_valid = 1'b0;
        min_out_ready = 1'b0;
        max_out_ready = 1'b0;
        errors        = 0;
        checks        = 0;
        busy_cycles   = 0;
        cur_interval  = 1;
        lfsr          = 16'd19;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        check_reset_state();
        run_whole_intervals();
        run_final_intervals();
        stall_on_full_fifos();
        timer_and_enable();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Ends a run that stopped making progress
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verification
src/spm_pkg.sv
src/spm_control.sv
src/interval_extrema.sv
src/extrema_fifo.sv
src/spm_top.sv
verification/spm_tb.sv
